// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := fpu_pkg.sv fpu_cmd_if.sv lzc.sv fadd.sv fpu_core.sv fpu_regs.sv fpu_top.sv tb_fpu.sv
HDRS := fpu_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported failures"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+.
fpu_pkg.sv
fpu_cmd_if.sv
lzc.sv
fadd.sv
fpu_core.sv
fpu_regs.sv
fpu_top.sv
tb_fpu.sv

// File: fadd.sv
`default_nettype none
`timescale 1ns/100ps

module fadd (
    input  logic [31:0] x,
    input  logic [31:0] y,
    output logic [31:0] res
);

    logic        x_sign;
    logic        y_sign;
    logic [7:0]  x_exp;
    logic [7:0]  y_exp;
    logic [22:0] x_man;
    logic [22:0] y_man;

    logic [8:0]  dexp_xy;
    logic [8:0]  dexp_yx;
    logic        swap;
    logic [7:0]  big_exp;
    logic [7:0]  exp_diff;
    logic [23:0] big_sig;
    logic [23:0] small_sig;
    logic        big_sign;
    logic        eff_add;
    logic        close_sel;

    assign {x_sign, x_exp, x_man} = x;
    assign {y_sign, y_exp, y_man} = y;

    // order operands by exponent
    assign dexp_xy   = {1'b0, x_exp} - {1'b0, y_exp};
    assign dexp_yx   = {1'b0, y_exp} - {1'b0, x_exp};
    assign swap      = dexp_xy[8];
    assign big_exp   = swap ? y_exp : x_exp;
    assign exp_diff  = swap ? dexp_yx[7:0] : dexp_xy[7:0];
    assign big_sig   = {1'b1, swap ? y_man : x_man};
    assign small_sig = {1'b1, swap ? x_man : y_man};
    assign big_sign  = swap ? y_sign : x_sign;
    assign eff_add   = ~(x_sign ^ y_sign);
    assign close_sel = ~eff_add & (exp_diff[7:1] == 7'd0);

    logic [49:0] far_shift;
    logic [26:0] far_small;
    logic [27:0] far_sum;
    logic        far_udf;
    logic        far_ovf;
    logic        far_sign;
    logic [7:0]  far_exp;
    logic [24:0] far_man;
    logic        far_sticky;

    // far path, smaller operand keeps guard, round and sticky bits
    assign far_shift = (exp_diff >= 8'd26) ? {26'b0, small_sig}
                                           : {small_sig, 26'b0} >> exp_diff;
    assign far_small = {far_shift[49:24], |far_shift[23:0]};
    assign far_sum   = eff_add ? {1'b0, big_sig, 3'b0} + {1'b0, far_small}
                               : {1'b0, big_sig, 3'b0} - {1'b0, far_small};

    assign far_udf  = ((big_exp == 8'd1) & ~far_sum[27] & ~far_sum[26])
                    | ((big_exp == 8'd0) & ~far_sum[27]);
    assign far_ovf  = ((big_exp == 8'd255) & (far_sum[27] | far_sum[26]))
                    | ((big_exp == 8'd254) & far_sum[27]);
    assign far_sign = far_udf ? 1'b0 : big_sign;

    always_comb begin
        if (far_sum[27]) begin
            far_exp    = big_exp + 8'd1;
            far_man    = far_sum[27:3];
            far_sticky = |far_sum[2:0];
        end else if (far_sum[26]) begin
            far_exp    = big_exp;
            far_man    = far_sum[26:2];
            far_sticky = |far_sum[1:0];
        end else begin
            // at most one bit lost, exponents differ by two or more here
            far_exp    = big_exp - 8'd1;
            far_man    = far_sum[25:1];
            far_sticky = far_sum[0];
        end
        if (far_udf) begin
            far_exp = 8'd0;
            far_man = 25'd0;
        end else if (far_ovf) begin
            far_exp = 8'hff;
            far_man = 25'd0;
        end
    end

    logic [24:0] cls_small;
    logic [25:0] cls_diff_bs;
    logic [25:0] cls_diff_sb;
    logic [24:0] cls_mag;
    logic [4:0]  cls_lz;
    logic [8:0]  cls_exp_raw;
    logic        cls_udf;
    logic        cls_sign;
    logic [7:0]  cls_exp;
    logic [24:0] cls_man;

    // close path, exact difference then normalise
    assign cls_small   = exp_diff[0] ? {1'b0, small_sig} : {small_sig, 1'b0};
    assign cls_diff_bs = {1'b0, big_sig, 1'b0} - {1'b0, cls_small};
    assign cls_diff_sb = {1'b0, cls_small} - {1'b0, big_sig, 1'b0};
    assign cls_mag     = cls_diff_bs[25] ? cls_diff_sb[24:0] : cls_diff_bs[24:0];

    lzc u_lzc (
        .x   (cls_mag),
        .res (cls_lz)
    );

    assign cls_exp_raw = {1'b0, big_exp} - {4'b0, cls_lz};
    assign cls_udf     = cls_exp_raw[8] | (cls_exp_raw == 9'd0) | (cls_mag == 25'd0);
    assign cls_sign    = ~cls_udf & (cls_diff_bs[25] ? ~big_sign : big_sign);
    assign cls_exp     = cls_udf ? 8'd0 : cls_exp_raw[7:0];
    assign cls_man     = cls_udf ? 25'd0 : cls_mag << cls_lz;

    logic [34:0] pre;
    logic        round_up;
    logic [24:0] sig_rnd;
    logic [7:0]  res_exp;
    logic [22:0] res_man;

    // sign, exponent, 24-bit significand, round bit, sticky
    assign pre = close_sel ? {cls_sign, cls_exp, cls_man, 1'b0}
                           : {far_sign, far_exp, far_man, far_sticky};

    // nearest even
    assign round_up = pre[1] & (pre[0] | pre[2]);
    assign sig_rnd  = {1'b0, pre[25:2]} + {24'd0, round_up};
    assign res_exp  = sig_rnd[24] ? pre[33:26] + 8'd1 : pre[33:26];
    assign res_man  = sig_rnd[24] ? 23'd0 : sig_rnd[22:0];

    assign res = {pre[34], res_exp, res_man};

endmodule

`default_nettype wire

// File: fpu_cmd_if.sv
`default_nettype none
`timescale 1ns/100ps
`include "fpu_defines.svh"

interface fpu_cmd_if;
    import fpu_pkg::*;

    // request, register block to core
    logic                   start;
    fpu_op_e                op;
    logic [`FPU_DATA_W-1:0] a;
    logic [`FPU_DATA_W-1:0] b;

    // completion, core to register block
    logic                   done;
    logic [`FPU_DATA_W-1:0] result;

    modport regs (
        output start,
        output op,
        output a,
        output b,
        input  done,
        input  result
    );

    modport core (
        input  start,
        input  op,
        input  a,
        input  b,
        output done,
        output result
    );

endinterface

`default_nettype wire

// File: fpu_core.sv
`default_nettype none
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_core (
    input logic     clk,
    input logic     rst_n,
    fpu_cmd_if.core cmd
);
    import fpu_pkg::*;

    localparam int SIGN_BIT = `FPU_DATA_W - 1;

    logic                   s1_valid;
    logic [`FPU_DATA_W-1:0] s1_a;
    logic [`FPU_DATA_W-1:0] s1_b;
    logic                   s2_valid;
    logic [`FPU_DATA_W-1:0] s2_res;
    logic [`FPU_DATA_W-1:0] sum;

    // stage 1, subtract is an add with b negated
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            s1_a <= cmd.a;
            s1_b <= {cmd.b[SIGN_BIT] ^ (cmd.op == FPU_OP_SUB), cmd.b[SIGN_BIT-1:0]};
        end
    end

    fadd u_fadd (
        .x   (s1_a),
        .y   (s1_b),
        .res (sum)
    );

    // stage 2
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_res <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= cmd.start;
            s2_valid <= s1_valid;
        end
    end

    assign cmd.done   = s2_valid;
    assign cmd.result = s2_res;

endmodule

`default_nettype wire

// File: fpu_defines.svh
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// wishbone window
`define FPU_DATA_W 32
`define FPU_ADDR_W 5
`define FPU_SEL_W  4

// register byte offsets
`define FPU_REG_A      5'h00
`define FPU_REG_B      5'h04
`define FPU_REG_CTRL   5'h08
`define FPU_REG_STATUS 5'h0C
`define FPU_REG_RESULT 5'h10

// ctrl and status bit positions
`define FPU_CTRL_START 0
`define FPU_CTRL_OP    1
`define FPU_STAT_BUSY  0
`define FPU_STAT_DONE  1

`endif

// File: fpu_pkg.sv
`default_nettype none

package fpu_pkg;

    // operation selected through CTRL.op
    typedef enum logic {
        FPU_OP_ADD = 1'b0,
        FPU_OP_SUB = 1'b1
    } fpu_op_e;

    // register block: is an operation outstanding
    typedef enum logic {
        REG_IDLE = 1'b0,
        REG_WAIT = 1'b1
    } fpu_state_e;

endpackage

`default_nettype wire

// File: fpu_regs.sv
`default_nettype none
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`FPU_ADDR_W-1:0] wb_adr,
    input  logic [`FPU_DATA_W-1:0] wb_dat_w,
    input  logic [`FPU_SEL_W-1:0]  wb_sel,
    output logic [`FPU_DATA_W-1:0] wb_dat_r,
    output logic                   wb_ack,
    fpu_cmd_if.regs                cmd
);
    import fpu_pkg::*;

    fpu_state_e             state;
    fpu_op_e                op_q;
    logic                   start_q;
    logic                   done_q;
    logic [`FPU_DATA_W-1:0] a_q;
    logic [`FPU_DATA_W-1:0] b_q;
    logic [`FPU_DATA_W-1:0] result_q;
    logic [`FPU_DATA_W-1:0] ctrl_word;
    logic [`FPU_DATA_W-1:0] stat_word;
    logic                   wr_en;
    logic                   go;

    function automatic logic [`FPU_DATA_W-1:0] merge_bytes(
        input logic [`FPU_DATA_W-1:0] cur,
        input logic [`FPU_DATA_W-1:0] wdat,
        input logic [`FPU_SEL_W-1:0]  sel
    );
        logic [`FPU_DATA_W-1:0] merged;
        merged = cur;
        for (int i = 0; i < `FPU_SEL_W; i++) begin
            if (sel[i]) begin
                merged[8*i +: 8] = wdat[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // writes land on the edge that closes the ack cycle
    assign wr_en = wb_cyc & wb_stb & wb_we & wb_ack;
    assign go    = wr_en & (wb_adr == `FPU_REG_CTRL) & wb_sel[0]
                 & wb_dat_w[`FPU_CTRL_START] & (state == REG_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            state    <= REG_IDLE;
            op_q     <= FPU_OP_ADD;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
            a_q      <= '0;
            b_q      <= '0;
            result_q <= '0;
        end else begin
            wb_ack  <= wb_cyc & wb_stb & ~wb_ack;
            start_q <= go;
            if (wr_en && wb_adr == `FPU_REG_A) begin
                a_q <= merge_bytes(a_q, wb_dat_w, wb_sel);
            end
            if (wr_en && wb_adr == `FPU_REG_B) begin
                b_q <= merge_bytes(b_q, wb_dat_w, wb_sel);
            end
            if (go) begin
                op_q   <= fpu_op_e'(wb_dat_w[`FPU_CTRL_OP]);
                state  <= REG_WAIT;
                done_q <= 1'b0;
            end
            if (cmd.done) begin
                result_q <= cmd.result;
                done_q   <= 1'b1;
                state    <= REG_IDLE;
            end
        end
    end

    always_comb begin
        ctrl_word = '0;
        ctrl_word[`FPU_CTRL_OP] = op_q;
        stat_word = '0;
        stat_word[`FPU_STAT_BUSY] = (state == REG_WAIT);
        stat_word[`FPU_STAT_DONE] = done_q;
    end

    // start always reads back as zero
    always_comb begin
        case (wb_adr)
            `FPU_REG_A:      wb_dat_r = a_q;
            `FPU_REG_B:      wb_dat_r = b_q;
            `FPU_REG_CTRL:   wb_dat_r = ctrl_word;
            `FPU_REG_STATUS: wb_dat_r = stat_word;
            `FPU_REG_RESULT: wb_dat_r = result_q;
            default:         wb_dat_r = '0;
        endcase
    end

    assign cmd.start = start_q;
    assign cmd.op    = op_q;
    assign cmd.a     = a_q;
    assign cmd.b     = b_q;

endmodule

`default_nettype wire

// File: fpu_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`FPU_ADDR_W-1:0] wb_adr,
    input  logic [`FPU_DATA_W-1:0] wb_dat_w,
    input  logic [`FPU_SEL_W-1:0]  wb_sel,
    output logic [`FPU_DATA_W-1:0] wb_dat_r,
    output logic                   wb_ack
);

    // request and result between register block and core
    fpu_cmd_if cmd_bus ();

    fpu_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cmd      (cmd_bus.regs)
    );

    fpu_core u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd_bus.core)
    );

endmodule

`default_nettype wire

// File: lzc.sv
`default_nettype none
`timescale 1ns/100ps

module lzc (
    input  logic [24:0] x,
    output logic [4:0]  res
);

    logic [31:0] pad;
    logic [31:0] step8;
    logic [31:0] step4;
    logic [31:0] step2;
    logic [31:0] step1;

    // a marker one after x makes a zero input count to 25
    assign pad = {x, 1'b1, 6'b0};

    // binary search, 16 then 8, 4, 2, 1
    assign res[4] = ~|pad[31:16];
    assign step8  = res[4] ? {pad[15:0], 16'b0} : pad;

    assign res[3] = ~|step8[31:24];
    assign step4  = res[3] ? {step8[23:0], 8'b0} : step8;

    assign res[2] = ~|step4[31:28];
    assign step2  = res[2] ? {step4[27:0], 4'b0} : step4;

    assign res[1] = ~|step2[31:30];
    assign step1  = res[1] ? {step2[29:0], 2'b0} : step2;

    assign res[0] = ~step1[31];

endmodule

`default_nettype wire

// File: tb_fpu.sv
`default_nettype none
`timescale 1ns/100ps
`include "fpu_defines.svh"

module tb_fpu;
    import fpu_pkg::*;

    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 20;
    localparam int NUM_VEC    = 11;
    localparam int NUM_RAND   = 40;

    typedef logic [`FPU_DATA_W-1:0] word_t;

    typedef struct packed {
        word_t   a;
        word_t   b;
        fpu_op_e op;
        word_t   want;
    } vec_t;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`FPU_ADDR_W-1:0] wb_adr;
    word_t                  wb_dat_w;
    logic [`FPU_SEL_W-1:0]  wb_sel;
    word_t                  wb_dat_r;
    logic                   wb_ack;

    int    errors;
    int    err_mark;
    int    tests_run;
    int    tests_failed;
    word_t rng;

    // directed cases over far path, close path, rounding, flush and overflow
    vec_t vecs [NUM_VEC] = '{
        '{32'h3F800000, 32'h40000000, FPU_OP_ADD, 32'h40400000},
        '{32'h3FC00000, 32'h3FA00000, FPU_OP_SUB, 32'h3E800000},
        '{32'h40490FDB, 32'h40490FDB, FPU_OP_SUB, 32'h00000000},
        '{32'hC0400000, 32'h3F800000, FPU_OP_ADD, 32'hC0000000},
        '{32'h3F800000, 32'hC0800000, FPU_OP_ADD, 32'hC0400000},
        '{32'h40200000, 32'h41200000, FPU_OP_SUB, 32'hC0F00000},
        '{32'h3F800000, 32'h3F7FFFFF, FPU_OP_SUB, 32'h33800000},
        '{32'h3F800000, 32'h33800000, FPU_OP_ADD, 32'h3F800000},
        '{32'h3F800000, 32'h34400000, FPU_OP_ADD, 32'h3F800002},
        '{32'h01000000, 32'h00C00000, FPU_OP_SUB, 32'h00000000},
        '{32'h7F7FFFFF, 32'h7F7FFFFF, FPU_OP_ADD, 32'h7F800000}
    };

    fpu_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // nonzero and below 2^20
    function automatic int rand_operand();
        rng = xorshift(rng);
        return (rng[19:0] == 20'd0) ? 1 : int'({12'd0, rng[19:0]});
    endfunction

    // exact for magnitudes below 2^24
    function automatic word_t int_to_float(input int v);
        word_t mag;
        int    msb;
        if (v == 0) begin
            return '0;
        end
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 24; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        return {v < 0, 8'(127 + msb), 23'(mag << (23 - msb))};
    endfunction

    function automatic word_t start_word(input fpu_op_e op);
        word_t w;
        w = '0;
        w[`FPU_CTRL_START] = 1'b1;
        w[`FPU_CTRL_OP] = op;
        return w;
    endfunction

    task automatic check_result(input string name, input word_t want, input word_t got);
        if (got !== want) begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_state(input string name, input fpu_state_e want,
                               input fpu_state_e got);
        if (got !== want) begin
            $display("Error at %0d ns: %s expected %s, got %s", $time, name, want.name(),
                     got.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("Error at %0d ns: %s expected %b, got %b", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [`FPU_ADDR_W-1:0] adr,
                             input word_t wdat, input logic [`FPU_SEL_W-1:0] sel,
                             output word_t rdat);
        int waited;
        waited = 0;
        rdat = 'x;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        wb_sel = sel;
        while (wb_ack !== 1'b1 && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wb_ack === 1'b1) begin
            rdat = wb_dat_r;
            if (waited != 1) begin
                $display("bus %s at offset %h was acknowledged after %0d cycles, not one",
                         we ? "write" : "read", adr, waited);
                errors++;
            end
        end else begin
            $display("bus %s at offset %h was never acknowledged", we ? "write" : "read", adr);
            errors++;
        end
        // held through the ack edge that commits a write
        @(posedge clk);
        #1;
        check_bit("wb_ack", 1'b0, wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [`FPU_ADDR_W-1:0] adr, input word_t dat,
                            input logic [`FPU_SEL_W-1:0] sel);
        word_t unused_rd;
        bus_cycle(1'b1, adr, dat, sel, unused_rd);
    endtask

    task automatic wb_read(input logic [`FPU_ADDR_W-1:0] adr, output word_t dat);
        bus_cycle(1'b0, adr, '0, '1, dat);
    endtask

    task automatic wait_done();
        word_t stat;
        int    polls;
        stat = '0;
        polls = 0;
        while (stat[`FPU_STAT_DONE] !== 1'b1 && polls < POLL_LIMIT) begin
            wb_read(`FPU_REG_STATUS, stat);
            polls++;
        end
        if (stat[`FPU_STAT_DONE] !== 1'b1) begin
            $display("wait_done: the operation did not complete after %0d status polls",
                     POLL_LIMIT);
            errors++;
        end
    endtask

    task automatic run_op(input word_t a, input word_t b, input fpu_op_e op,
                          output word_t res);
        wb_write(`FPU_REG_A, a, '1);
        wb_write(`FPU_REG_B, b, '1);
        wb_write(`FPU_REG_CTRL, start_word(op), '1);
        wait_done();
        wb_read(`FPU_REG_RESULT, res);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        err_mark = errors;
    endtask

    initial begin
        word_t rd;
        int    ia;
        int    ib;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        errors = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        rng = 32'd52260;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_bit("wb_ack", 1'b0, wb_ack);
        wb_read(`FPU_REG_STATUS, rd);
        check_state("status.busy", REG_IDLE, fpu_state_e'(rd[`FPU_STAT_BUSY]));
        check_result("status", '0, rd);
        wb_write(`FPU_REG_A, 32'h12345678, '1);
        wb_read(`FPU_REG_A, rd);
        check_result("reg_a", 32'h12345678, rd);
        wb_write(`FPU_REG_B, 32'hAABBCCDD, '1);
        wb_write(`FPU_REG_B, 32'h00EE0000, 4'b0100);
        wb_read(`FPU_REG_B, rd);
        check_result("reg_b", 32'hAAEECCDD, rd);
        wb_write(5'h14, 32'hFFFFFFFF, '1);
        wb_read(5'h14, rd);
        check_result("unmapped", '0, rd);
        wb_write(`FPU_REG_RESULT, 32'hFFFFFFFF, '1);
        wb_read(`FPU_REG_RESULT, rd);
        check_result("result", '0, rd);
        end_test("register access");

        for (int i = 0; i < NUM_VEC; i++) begin
            run_op(vecs[i].a, vecs[i].b, vecs[i].op, rd);
            check_result("result", vecs[i].want, rd);
            end_test($sformatf("vector %0d %h %s %h", i, vecs[i].a, vecs[i].op.name(),
                               vecs[i].b));
        end

        // second start lands while the first is still in flight
        wb_write(`FPU_REG_A, 32'h3F800000, '1);
        wb_write(`FPU_REG_B, 32'h40000000, '1);
        wb_write(`FPU_REG_CTRL, start_word(FPU_OP_ADD), '1);
        wb_write(`FPU_REG_CTRL, start_word(FPU_OP_SUB), '1);
        wait_done();
        wb_read(`FPU_REG_RESULT, rd);
        check_result("result", 32'h40400000, rd);
        wb_read(`FPU_REG_CTRL, rd);
        check_result("ctrl", '0, rd);
        end_test("start while busy");

        wb_read(`FPU_REG_STATUS, rd);
        check_state("status.busy", REG_IDLE, fpu_state_e'(rd[`FPU_STAT_BUSY]));
        check_result("status.done", 32'd1, {31'd0, rd[`FPU_STAT_DONE]});
        wb_write(`FPU_REG_CTRL, start_word(FPU_OP_SUB), '1);
        wb_read(`FPU_REG_STATUS, rd);
        check_state("status.busy", REG_WAIT, fpu_state_e'(rd[`FPU_STAT_BUSY]));
        check_result("status.done", '0, {31'd0, rd[`FPU_STAT_DONE]});
        wait_done();
        wb_read(`FPU_REG_RESULT, rd);
        check_result("result", 32'hBF800000, rd);
        end_test("done flag");

        // integer operands keep sum and difference exact
        for (int i = 0; i < NUM_RAND; i++) begin
            ia = rand_operand();
            ib = rand_operand();
            run_op(int_to_float(ia), int_to_float(ib), FPU_OP_ADD, rd);
            check_result("result", int_to_float(ia + ib), rd);
            end_test($sformatf("random %0d + %0d", ia, ib));
            run_op(int_to_float(ia), int_to_float(ib), FPU_OP_SUB, rd);
            check_result("result", int_to_float(ia - ib), rd);
            end_test($sformatf("random %0d - %0d", ia, ib));
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
